/* hdl/board_pkg.sv */
// Shared widths, counts and vector types for the board glue RTL and its testbench
package board_pkg;

    // Interrupt lines from the NIC core
    localparam int irq_count = 32;

    // Cycles a stretched interrupt stays high
    localparam int irq_stretch_len = 10;

    // Buttons u, l, d, r, c in bits 12 down to 8, switches in bits 7 to 0
    localparam int gpio_width = 13;

    // Agreeing samples needed before a debounced output moves
    localparam int debounce_depth = 4;

    // Clock cycles between debounce samples
    localparam int debounce_rate_default = 250000;

    // Clock edges before the auxiliary reset releases
    localparam int reset_sync_stages = 4;

    // Bit positions inside the packed GPIO vector
    localparam int gpio_btnu_bit = 12;
    localparam int gpio_btnl_bit = 11;
    localparam int gpio_btnd_bit = 10;
    localparam int gpio_btnr_bit = 9;
    localparam int gpio_btnc_bit = 8;
    localparam int gpio_sw_msb = 7;

    typedef logic [irq_count-1:0] irq_vec_t;

    typedef logic [gpio_width-1:0] gpio_vec_t;

endpackage

/* hdl/reset_sync.sv */
// Reset synchronizer: asserts at once on lost lock, releases after a fixed count of clock edges
`timescale 1ns/10ps

module reset_sync #(
    parameter int stages = board_pkg::reset_sync_stages
) (
    input  logic clk,
    input  logic locked,
    output logic rst
);

    // Zeros enter at stage 0 after lock and leave as rst
    logic [stages-1:0] chain;

    always_ff @(posedge clk or negedge locked) begin
        if (!locked) begin
            chain <= '1;
        end else begin
            chain <= {chain[stages-2:0], 1'b0};
        end
    end

    assign rst = chain[stages-1];

    // Domain is held in reset whenever the clock manager is not locked
    a_rst_while_unlocked : assert property (
        @(posedge clk) !locked |-> rst
    ) else $error("reset_sync: rst low while locked is low");

endmodule

/* hdl/switch_debounce.sv */
// Button and switch debouncer: samples each line at a divided rate and filters on a short history
`timescale 1ns/10ps

module switch_debounce #(
    parameter int sample_period = board_pkg::debounce_rate_default
) (
    input  logic                 zynq_pl_clk,
    input  logic                 zynq_pl_reset,
    input  board_pkg::gpio_vec_t raw,
    output board_pkg::gpio_vec_t clean
);

    localparam int cnt_w = $clog2(sample_period + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(sample_period - 1);

    logic [cnt_w-1:0] sample_cnt;
    logic             sample_tick;

    // Newest sample sits in bit 0
    logic [board_pkg::debounce_depth-1:0] hist [board_pkg::gpio_width];

    // Free-running rate divider
    assign sample_tick = (sample_cnt == cnt_last);

    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            sample_cnt <= '0;
        end else if (sample_tick) begin
            sample_cnt <= '0;
        end else begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    // Shift every line once per tick
    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            for (int i = 0; i < board_pkg::gpio_width; i++) begin
                hist[i] <= '0;
            end
        end else if (sample_tick) begin
            for (int i = 0; i < board_pkg::gpio_width; i++) begin
                hist[i] <= {hist[i][board_pkg::debounce_depth-2:0], raw[i]};
            end
        end
    end

    // Move only on a unanimous history, otherwise hold
    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            clean <= '0;
        end else begin
            for (int i = 0; i < board_pkg::gpio_width; i++) begin
                if (&hist[i]) begin
                    clean[i] <= 1'b1;
                end else if (~|hist[i]) begin
                    clean[i] <= 1'b0;
                end
            end
        end
    end

    // History moves on the tick, so the output can only follow one edge later
    a_clean_after_tick : assert property (
        @(posedge zynq_pl_clk) disable iff (zynq_pl_reset)
        $changed(clean) |-> $past(sample_tick, 2)
    ) else $error("switch_debounce: clean changed outside the cycle after a tick");

endmodule

/* hdl/irq_stretch.sv */
// Interrupt stretcher: widens each core interrupt pulse to a fixed length for the processor
`timescale 1ns/10ps

module irq_stretch (
    input  logic                zynq_pl_clk,
    input  logic                zynq_pl_reset,
    input  board_pkg::irq_vec_t irq,
    output board_pkg::irq_vec_t zynq_irq
);

    // Word 0 holds the newest sample of all lines
    board_pkg::irq_vec_t hist [board_pkg::irq_stretch_len];

    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            for (int j = 0; j < board_pkg::irq_stretch_len; j++) begin
                hist[j] <= '0;
            end
        end else begin
            hist[0] <= irq;
            for (int j = 1; j < board_pkg::irq_stretch_len; j++) begin
                hist[j] <= hist[j-1];
            end
        end
    end

    // Any sample still in the window keeps the line high
    always_comb begin
        zynq_irq = '0;
        for (int j = 0; j < board_pkg::irq_stretch_len; j++) begin
            zynq_irq = zynq_irq | hist[j];
        end
    end

    // A sampled request is visible to the processor in the very next cycle
    a_irq_seen : assert property (
        @(posedge zynq_pl_clk) disable iff (zynq_pl_reset)
        $past(!zynq_pl_reset) |-> ((zynq_irq & $past(irq)) == $past(irq))
    ) else $error("irq_stretch: sampled interrupt missing from zynq_irq");

endmodule

/* hdl/board_glue.sv */
// Board glue top level: debounced GPIO, stretched interrupts and the 125 MHz domain reset
`timescale 1ns/10ps

module board_glue #(
    parameter int debounce_period = board_pkg::debounce_rate_default
) (
    // Programmable-logic clock and reset from the processor
    input  logic                zynq_pl_clk,
    input  logic                zynq_pl_reset,

    // Auxiliary clock and its clock-manager lock
    input  logic                clk_125mhz,
    input  logic                mmcm_locked,

    // Raw buttons and switches
    input  logic                btnu,
    input  logic                btnl,
    input  logic                btnd,
    input  logic                btnr,
    input  logic                btnc,
    input  logic [7:0]          sw,

    // Debounced buttons and switches
    output logic                btnu_int,
    output logic                btnl_int,
    output logic                btnd_int,
    output logic                btnr_int,
    output logic                btnc_int,
    output logic [7:0]          sw_int,

    // Core interrupts in, stretched interrupts out
    input  board_pkg::irq_vec_t irq,
    output board_pkg::irq_vec_t zynq_irq,

    // Synchronous reset for the 125 MHz domain
    output logic                rst_125mhz
);

    board_pkg::gpio_vec_t gpio_raw;
    board_pkg::gpio_vec_t gpio_clean;

    // Buttons on top, switches below
    assign gpio_raw[board_pkg::gpio_btnu_bit] = btnu;
    assign gpio_raw[board_pkg::gpio_btnl_bit] = btnl;
    assign gpio_raw[board_pkg::gpio_btnd_bit] = btnd;
    assign gpio_raw[board_pkg::gpio_btnr_bit] = btnr;
    assign gpio_raw[board_pkg::gpio_btnc_bit] = btnc;
    assign gpio_raw[board_pkg::gpio_sw_msb:0] = sw;

    switch_debounce #(
        .sample_period (debounce_period)
    ) u_switch_debounce (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .raw           (gpio_raw),
        .clean         (gpio_clean)
    );

    // Same bit order on the way out
    assign btnu_int = gpio_clean[board_pkg::gpio_btnu_bit];
    assign btnl_int = gpio_clean[board_pkg::gpio_btnl_bit];
    assign btnd_int = gpio_clean[board_pkg::gpio_btnd_bit];
    assign btnr_int = gpio_clean[board_pkg::gpio_btnr_bit];
    assign btnc_int = gpio_clean[board_pkg::gpio_btnc_bit];
    assign sw_int   = gpio_clean[board_pkg::gpio_sw_msb:0];

    irq_stretch u_irq_stretch (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .irq           (irq),
        .zynq_irq      (zynq_irq)
    );

    // Driven only by the lock, the processor reset is not involved here
    reset_sync #(
        .stages (board_pkg::reset_sync_stages)
    ) u_reset_sync (
        .clk    (clk_125mhz),
        .locked (mmcm_locked),
        .rst    (rst_125mhz)
    );

endmodule

/* sim/board_glue_tb.sv */
// Directed testbench for board_glue: run it as top module board_glue_tb with the sources in all.f
`timescale 1ns/10ps

module board_glue_tb;

    localparam int tb_debounce_period = 8;
    localparam int settle_cycles = (board_pkg::debounce_depth + 1) * tb_debounce_period;
    localparam int glitch_sweep_cycles = tb_debounce_period * (tb_debounce_period + 1);
    localparam int stretch_window = 30;
    localparam int reset_cycles = 5;

    // Cycle budgets of reset and the five tests, plus margin
    localparam int budget_cycles = reset_cycles + 2 + 20 + 4 * settle_cycles
                                 + (glitch_sweep_cycles + settle_cycles + 4)
                                 + 2 * (stretch_window + 2) + 100;

    logic                 zynq_pl_clk;
    logic                 zynq_pl_reset;
    logic                 clk_125mhz;
    logic                 mmcm_locked;
    logic                 btnu;
    logic                 btnl;
    logic                 btnd;
    logic                 btnr;
    logic                 btnc;
    logic [7:0]           sw;
    logic                 btnu_int;
    logic                 btnl_int;
    logic                 btnd_int;
    logic                 btnr_int;
    logic                 btnc_int;
    logic [7:0]           sw_int;
    board_pkg::irq_vec_t  irq;
    board_pkg::irq_vec_t  zynq_irq;
    logic                 rst_125mhz;

    board_pkg::gpio_vec_t clean_obs;
    board_pkg::gpio_vec_t settled_gpio;
    logic [15:0]          lfsr_state;
    int                   error_count;
    int                   tests_run;
    int                   tests_failed;

    board_glue #(
        .debounce_period (tb_debounce_period)
    ) UUT (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .clk_125mhz    (clk_125mhz),
        .mmcm_locked   (mmcm_locked),
        .btnu          (btnu),
        .btnl          (btnl),
        .btnd          (btnd),
        .btnr          (btnr),
        .btnc          (btnc),
        .sw            (sw),
        .btnu_int      (btnu_int),
        .btnl_int      (btnl_int),
        .btnd_int      (btnd_int),
        .btnr_int      (btnr_int),
        .btnc_int      (btnc_int),
        .sw_int        (sw_int),
        .irq           (irq),
        .zynq_irq      (zynq_irq),
        .rst_125mhz    (rst_125mhz)
    );

    // Buttons u, l, d, r, c in bits 12 to 8, switches below
    assign clean_obs = {btnu_int, btnl_int, btnd_int, btnr_int, btnc_int, sw_int};

    initial begin
        zynq_pl_clk = 1'b0;
        forever #50 zynq_pl_clk = ~zynq_pl_clk;
    end

    initial begin
        clk_125mhz = 1'b0;
        forever #40 clk_125mhz = ~clk_125mhz;
    end

    initial begin
        #(budget_cycles * 100);
        $display("Watchdog: run did not finish within %0d clock cycles", budget_cycles);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // One LFSR step per bit, newest bit lands in bit 0
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge zynq_pl_clk);
            #10;
        end
    endtask

    task automatic drive_gpio(input board_pkg::gpio_vec_t value);
        btnu = value[12];
        btnl = value[11];
        btnd = value[10];
        btnr = value[9];
        btnc = value[8];
        sw   = value[7:0];
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %0d ns: %s expected 0x%0h, got 0x%0h",
                     $time, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("Test %-16s passed", name);
        end else begin
            tests_failed++;
            $display("Test %-16s failed with %0d errors", name, error_count - errors_at_start);
        end
    endtask

    task automatic reset_state_test();
        int start_errors;
        start_errors = error_count;
        check_value("debounced gpio after reset", 0, clean_obs);
        check_value("zynq_irq after reset", 0, zynq_irq);
        check_value("rst_125mhz while unlocked", 1, rst_125mhz);
        report_test("reset state", start_errors);
    endtask

    task automatic reset_release_test();
        int start_errors;
        start_errors = error_count;
        @(posedge clk_125mhz);
        #10;
        mmcm_locked = 1'b1;
        // High through the third edge, low after the fourth
        for (int e = 1; e <= 4; e++) begin
            @(posedge clk_125mhz);
            #1;
            check_value($sformatf("rst_125mhz after edge %0d", e), (e < 4), rst_125mhz);
        end
        @(posedge clk_125mhz);
        #10;
        mmcm_locked = 1'b0;
        #1;
        check_value("rst_125mhz right after lock loss", 1, rst_125mhz);
        #10;
        mmcm_locked = 1'b1;
        repeat (4) @(posedge clk_125mhz);
        #1;
        check_value("rst_125mhz after relock", 0, rst_125mhz);
        report_test("reset release", start_errors);
    endtask

    task automatic stable_input_test();
        logic [31:0] pattern;
        int          start_errors;
        start_errors = error_count;
        pattern = '0;
        for (int p = 0; p < 2; p++) begin
            draw_bits(board_pkg::gpio_width, pattern);
            step_cycles(1);
            drive_gpio(pattern[board_pkg::gpio_width-1:0]);
            step_cycles(settle_cycles);
            check_value("debounced gpio after settling", pattern, clean_obs);
            step_cycles(settle_cycles);
            check_value("debounced gpio still held", pattern, clean_obs);
        end
        settled_gpio = pattern[board_pkg::gpio_width-1:0];
        report_test("stable input", start_errors);
    endtask

    task automatic glitch_test();
        logic [31:0]          pick;
        int                   line;
        board_pkg::gpio_vec_t flipped;
        string                what;
        int                   start_errors;
        start_errors = error_count;
        draw_bits(4, pick);
        line = pick % board_pkg::gpio_width;
        flipped = settled_gpio;
        flipped[line] = ~flipped[line];
        what = $sformatf("debounced gpio with glitch on line %0d", line);
        check_value("debounced gpio before glitch", settled_gpio, clean_obs);
        step_cycles(1);
        // Spacing of one period plus one lets exactly one glitch meet a sample tick
        for (int g = 0; g < tb_debounce_period; g++) begin
            drive_gpio(flipped);
            step_cycles(1);
            drive_gpio(settled_gpio);
            check_value(what, settled_gpio, clean_obs);
            for (int i = 0; i < tb_debounce_period; i++) begin
                step_cycles(1);
                check_value(what, settled_gpio, clean_obs);
            end
        end
        for (int i = 0; i < settle_cycles; i++) begin
            step_cycles(1);
            check_value(what, settled_gpio, clean_obs);
        end
        report_test("glitch", start_errors);
    endtask

    // Pulse a line, with a second pulse gap cycles later when gap is nonzero
    task automatic stretch_count(input int line, input int gap, input int expected);
        board_pkg::irq_vec_t mask;
        int                  high_cnt;
        mask = '0;
        mask[line] = 1'b1;
        high_cnt = 0;
        irq = mask;
        for (int i = 0; i < stretch_window; i++) begin
            step_cycles(1);
            irq = (gap > 0 && i == gap - 1) ? mask : '0;
            check_value("zynq_irq on other lines", 0, zynq_irq & ~mask);
            if (zynq_irq[line]) begin
                high_cnt++;
            end
        end
        check_value($sformatf("high cycles on zynq_irq[%0d]", line), expected, high_cnt);
    endtask

    task automatic stretch_test();
        logic [31:0] pick;
        int          start_errors;
        start_errors = error_count;
        draw_bits(5, pick);
        step_cycles(1);
        check_value("zynq_irq idle", 0, zynq_irq);
        stretch_count(pick, 0, board_pkg::irq_stretch_len);
        step_cycles(1);
        stretch_count(pick, 3, board_pkg::irq_stretch_len + 3);
        report_test("irq stretch", start_errors);
    endtask

    initial begin
        zynq_pl_reset = 1'b1;
        mmcm_locked = 1'b1;
        btnu = 1'b0;
        btnl = 1'b0;
        btnd = 1'b0;
        btnr = 1'b0;
        btnc = 1'b0;
        sw = '0;
        irq = '0;
        settled_gpio = '0;
        lfsr_state = 16'd25;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        // Falling lock edge presets the reset chain
        #1;
        mmcm_locked = 1'b0;
        repeat (reset_cycles) @(posedge zynq_pl_clk);
        #10;
        zynq_pl_reset = 1'b0;
        step_cycles(1);

        reset_state_test();
        reset_release_test();
        stable_input_test();
        glitch_test();
        stretch_test();

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
hdl/board_pkg.sv
hdl/reset_sync.sv
hdl/switch_debounce.sv
hdl/irq_stretch.sv
hdl/board_glue.sv
sim/board_glue_tb.sv

/* Bender.yml */
package:
  name: board_glue

dependencies: {}

sources:
  # Shared package first, then the blocks, then the top level
  - hdl/board_pkg.sv
  - hdl/reset_sync.sv
  - hdl/switch_debounce.sv
  - hdl/irq_stretch.sv
  - hdl/board_glue.sv

  # Simulation only
  - target: test
    files:
      - sim/board_glue_tb.sv
